/* flist.f */
exec_pkg.sv
exec_alu.sv
exec_unit.sv
mem_access.sv
data_ram.sv
exec_top.sv
tb_exec_top.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, and judge the run from its log

rm -f sim.log

verilator --binary --timing --top-module tb_exec_top -f flist.f -o tb_exec_top &&
    ./obj_dir/tb_exec_top > sim.log 2>&1 ||
    echo "build or simulation step failed"

[ -f sim.log ] && cat sim.log

grep -qF "*** TEST PASSED ***" sim.log && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }

/* tb_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top import exec_pkg::*; ();

    localparam int ram_words  = 256;
    localparam int mem_bytes  = ram_words * 4;
    localparam int wait_limit = 200;

    logic        clock;
    logic        reset;
    logic        uop_valid;
    logic        uop_ready;
    uop_t        uop;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        wb_valid;
    logic        wb_ready;
    wb_t         wb;

    // expectations in issue order
    wb_t         exp_wb_q[$];
    string       wb_name_q[$];
    logic [31:0] exp_redir_q[$];
    string       redir_name_q[$];
    logic [31:0] store_addrs[$];

    // byte image of the data ram
    logic [7:0]  shadow [mem_bytes];

    int          wb_errors;
    int          redirect_errors;
    int          protocol_errors;
    int          misc_errors;
    logic        stall_mode;

    exec_top #(
        .ram_words (ram_words)
    ) u_dut (
        .clock          (clock),
        .reset          (reset),
        .uop_valid      (uop_valid),
        .uop_ready      (uop_ready),
        .uop            (uop),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready),
        .wb             (wb)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // random writeback back-pressure while stall_mode is set
    initial begin
        wb_ready = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            wb_ready = stall_mode ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    // ---------------------------------------------------------------------------
    // reference model
    // ---------------------------------------------------------------------------

    function automatic logic [31:0] alu_result(input alu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return 32'($signed(a) >>> b[4:0]);
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input br_cond_e cond, input logic [31:0] a,
                                          input logic [31:0] b);
        case (cond)
            br_eq:   return a == b;
            br_ne:   return a != b;
            br_lt:   return $signed(a) < $signed(b);
            br_ge:   return !($signed(a) < $signed(b));
            br_ltu:  return a < b;
            default: return !(a < b);
        endcase
    endfunction

    function automatic logic [31:0] load_from_shadow(input logic [31:0] addr,
                                                     input mem_size_e size,
                                                     input logic is_unsigned);
        logic [9:0]  a;
        logic [7:0]  b0;
        logic [15:0] h0;
        a  = addr[9:0];
        b0 = shadow[a];
        h0 = {shadow[a + 10'd1], shadow[a]};
        case (size)
            size_byte: return is_unsigned ? {24'b0, b0} : {{24{b0[7]}}, b0};
            size_half: return is_unsigned ? {16'b0, h0} : {{16{h0[15]}}, h0};
            default:   return {shadow[a + 10'd3], shadow[a + 10'd2], h0};
        endcase
    endfunction

    function automatic void store_to_shadow(input logic [31:0] addr, input mem_size_e size,
                                            input logic [31:0] data);
        logic [9:0] a;
        a = addr[9:0];
        shadow[a] = data[7:0];
        if (size != size_byte) begin
            shadow[a + 10'd1] = data[15:8];
        end
        if (size == size_word) begin
            shadow[a + 10'd2] = data[23:16];
            shadow[a + 10'd3] = data[31:24];
        end
    endfunction

    // expected writeback and redirect target of one micro-op
    function automatic void predict_uop(input uop_t u, output wb_t w, output logic [31:0] tgt);
        logic [31:0] a;
        logic [31:0] b;
        case (u.src_sel)
            src_rs1_rs2: begin
                a = u.rs1;
                b = u.rs2;
            end
            src_rs1_imm: begin
                a = u.rs1;
                b = u.imm;
            end
            src_pc_imm: begin
                a = u.pc;
                b = u.imm;
            end
            default: begin
                a = u.imm;
                b = 32'b0;
            end
        endcase
        w.rd        = u.rd;
        w.reg_write = u.reg_write && u.flow != flow_branch && u.mem_kind != mem_store;
        w.data      = alu_result(u.alu_op, a, b);
        if (u.flow == flow_jal || u.flow == flow_jalr) begin
            w.data = u.pc + 32'd4;
        end
        if (u.mem_kind == mem_load) begin
            w.data = load_from_shadow(u.rs1 + u.imm, u.mem_size, u.mem_unsigned);
        end else if (u.mem_kind == mem_store) begin
            w.data = 32'b0;
        end
        case (u.flow)
            flow_branch: tgt = branch_taken(u.br_cond, u.rs1, u.rs2) ? u.pc + u.imm
                                                                      : u.pc + 32'd4;
            flow_jal:    tgt = u.pc + u.imm;
            flow_jalr:   tgt = (u.rs1 + u.imm) & 32'hffff_fffe;
            default:     tgt = 32'b0;
        endcase
    endfunction

    // ---------------------------------------------------------------------------
    // compare tasks
    // ---------------------------------------------------------------------------

    task automatic check_wb(input string name, input wb_t expected, input wb_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: wb expected rd=%0d we=%0b data=%h actual rd=%0d we=%0b data=%h",
                     name, expected.rd, expected.reg_write, expected.data,
                     actual.rd, actual.reg_write, actual.data);
            wb_errors++;
        end
    endtask

    task automatic check_redirect(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: redirect expected %h actual %h", name, expected, actual);
            redirect_errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // ---------------------------------------------------------------------------
    // stimulus builders
    // ---------------------------------------------------------------------------

    function automatic logic [31:0] small_imm(input logic even);
        logic [31:0] r;
        r = $urandom;
        return {{20{r[11]}}, r[11:1], r[0] & ~even};
    endfunction

    function automatic uop_t base_uop();
        uop_t u;
        u           = '0;
        u.rd        = 5'($urandom_range(31));
        u.reg_write = 1'b1;
        u.pc        = $urandom & 32'hffff_fffc;
        u.imm       = $urandom;
        u.rs1       = $urandom;
        u.rs2       = $urandom;
        return u;
    endfunction

    function automatic uop_t alu_uop();
        uop_t u;
        u           = base_uop();
        u.src_sel   = src_sel_e'(2'($urandom_range(3)));
        u.alu_op    = alu_op_e'(4'($urandom_range(9)));
        u.reg_write = 1'($urandom_range(1));
        // auipc and lui are plain adds
        if (u.src_sel == src_pc_imm || u.src_sel == src_imm_zero) begin
            u.alu_op = alu_add;
        end
        if (u.src_sel == src_rs1_imm) begin
            u.imm = small_imm(1'b0);
        end
        if (u.src_sel == src_imm_zero) begin
            u.imm[11:0] = 12'b0;
        end
        return u;
    endfunction

    function automatic uop_t branch_uop(input br_cond_e cond, input logic [31:0] a,
                                        input logic [31:0] b);
        uop_t u;
        u         = base_uop();
        u.flow    = flow_branch;
        u.br_cond = cond;
        u.alu_op  = alu_sub;
        u.rs1     = a;
        u.rs2     = b;
        u.imm     = small_imm(1'b1);
        return u;
    endfunction

    function automatic uop_t jump_uop(input logic is_jalr);
        uop_t u;
        u = base_uop();
        if (is_jalr) begin
            u.flow = flow_jalr;
            u.imm  = small_imm(1'b0);
        end else begin
            u.flow = flow_jal;
            u.imm  = small_imm(1'b1);
        end
        return u;
    endfunction

    // aligned byte address inside the given word
    function automatic logic [31:0] place_addr(input logic [31:0] word_addr,
                                               input mem_size_e size);
        logic [1:0] off;
        off = 2'($urandom_range(3));
        case (size)
            size_byte: return {word_addr[31:2], off};
            size_half: return {word_addr[31:2], off[1], 1'b0};
            default:   return {word_addr[31:2], 2'b00};
        endcase
    endfunction

    function automatic uop_t mem_uop(input mem_kind_e kind, input mem_size_e size,
                                     input logic is_unsigned, input logic [31:0] addr);
        uop_t u;
        u              = base_uop();
        u.mem_kind     = kind;
        u.mem_size     = size;
        u.mem_unsigned = is_unsigned;
        u.imm          = small_imm(1'b0);
        u.rs1          = addr - u.imm;
        return u;
    endfunction

    function automatic mem_size_e rand_size();
        return mem_size_e'(2'($urandom_range(2)));
    endfunction

    // hand one micro-op to the DUT and wait for its acceptance
    task automatic issue(input uop_t u, input string name);
        wb_t         exp_w;
        logic [31:0] exp_t;
        int          waited;
        predict_uop(u, exp_w, exp_t);
        exp_wb_q.push_back(exp_w);
        wb_name_q.push_back(name);
        if (u.flow != flow_none) begin
            exp_redir_q.push_back(exp_t);
            redir_name_q.push_back(name);
        end
        if (u.mem_kind == mem_store) begin
            store_to_shadow(u.rs1 + u.imm, u.mem_size, u.rs2);
            store_addrs.push_back(u.rs1 + u.imm);
        end
        uop       = u;
        uop_valid = 1'b1;
        waited    = 0;
        @(posedge clock);
        while (uop_ready !== 1'b1 && waited < wait_limit) begin
            @(posedge clock);
            waited++;
        end
        if (uop_ready !== 1'b1) begin
            abort_run("uop_ready stayed low");
        end else begin
            #1;
            uop_valid = 1'b0;
        end
    endtask

    // ---------------------------------------------------------------------------
    // result checking
    // ---------------------------------------------------------------------------

    initial begin : compare_loop
        wb_t  held_wb;
        logic held;
        held            = 1'b0;
        wb_errors       = 0;
        redirect_errors = 0;
        protocol_errors = 0;
        forever begin
            @(posedge clock);
            if (reset) begin
                held = 1'b0;
            end else begin
                if (held && (!wb_valid || wb !== held_wb)) begin
                    $display("writeback changed while wb_ready was low");
                    protocol_errors++;
                end
                held    = wb_valid && !wb_ready;
                held_wb = wb;
                if (wb_valid && wb_ready) begin
                    if (exp_wb_q.size() == 0) begin
                        $display("writeback arrived with nothing outstanding");
                        protocol_errors++;
                    end else begin
                        check_wb(wb_name_q.pop_front(), exp_wb_q.pop_front(), wb);
                    end
                end
                if (redirect_valid) begin
                    if (exp_redir_q.size() == 0) begin
                        $display("redirect pulse with no flow op outstanding");
                        protocol_errors++;
                    end else begin
                        check_redirect(redir_name_q.pop_front(), exp_redir_q.pop_front(),
                                       redirect_pc);
                    end
                end
            end
        end
    end

    // ---------------------------------------------------------------------------
    // stimulus
    // ---------------------------------------------------------------------------

    initial begin : producer
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] neg;
        mem_size_e   sz;
        int          kind;
        int          waited;
        int          total;
        void'($urandom(32'hcfbe));
        misc_errors = 0;
        stall_mode  = 1'b0;
        reset       = 1'b1;
        uop_valid   = 1'b0;
        uop         = '0;
        for (int i = 0; i < mem_bytes; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        // quiet outputs right after reset
        repeat (3) begin
            @(posedge clock);
            if (wb_valid !== 1'b0 || redirect_valid !== 1'b0) begin
                $display("wb_valid or redirect_valid not low right after reset");
                misc_errors++;
            end
            if (uop_ready !== 1'b1) begin
                $display("uop_ready not high right after reset");
                misc_errors++;
            end
        end
        #1;

        for (int i = 0; i < 40; i++) begin
            issue(alu_uop(), "alu");
        end

        // equal, neg vs pos, pos vs neg, small vs big
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 4; k++) begin
                a   = $urandom & 32'h3fff_ffff;
                b   = a + 32'd1 + ($urandom & 32'hffff);
                neg = a | 32'h8000_0000;
                case (k)
                    0: issue(branch_uop(br_cond_e'(3'(c)), a, a), "branch");
                    1: issue(branch_uop(br_cond_e'(3'(c)), neg, b), "branch");
                    2: issue(branch_uop(br_cond_e'(3'(c)), b, neg), "branch");
                    default: issue(branch_uop(br_cond_e'(3'(c)), a, b), "branch");
                endcase
            end
        end

        for (int i = 0; i < 8; i++) begin
            issue(jump_uop(1'b0), "jal");
            issue(jump_uop(1'b1), "jalr");
        end

        for (int i = 0; i < 24; i++) begin
            sz = rand_size();
            issue(mem_uop(mem_store, sz, 1'b0, place_addr($urandom, sz)), "store");
        end
        for (int i = 0; i < 24; i++) begin
            sz = rand_size();
            a  = store_addrs[$urandom_range(store_addrs.size() - 1)];
            issue(mem_uop(mem_load, sz, 1'($urandom_range(1)), place_addr(a, sz)), "load");
        end

        // mixed traffic under writeback back-pressure
        stall_mode = 1'b1;
        for (int i = 0; i < 60; i++) begin
            kind = $urandom_range(4);
            sz   = rand_size();
            case (kind)
                0: issue(alu_uop(), "mixed alu");
                1: issue(branch_uop(br_cond_e'(3'($urandom_range(5))), $urandom, $urandom),
                         "mixed branch");
                2: issue(jump_uop(1'($urandom_range(1))), "mixed jump");
                3: issue(mem_uop(mem_store, sz, 1'b0, place_addr($urandom, sz)),
                         "mixed store");
                default: begin
                    a = store_addrs[$urandom_range(store_addrs.size() - 1)];
                    issue(mem_uop(mem_load, sz, 1'($urandom_range(1)), place_addr(a, sz)),
                          "mixed load");
                end
            endcase
        end
        stall_mode = 1'b0;

        waited = 0;
        while ((exp_wb_q.size() != 0 || exp_redir_q.size() != 0) && waited < wait_limit) begin
            @(posedge clock);
            waited++;
        end
        if (exp_wb_q.size() != 0 || exp_redir_q.size() != 0) begin
            abort_run("writebacks or redirects still missing at the end");
        end else begin
            total = wb_errors + redirect_errors + protocol_errors + misc_errors;
            $display("errors: wb %0d, redirect %0d, protocol %0d, other %0d",
                     wb_errors, redirect_errors, protocol_errors, misc_errors);
            if (total == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top import exec_pkg::*; #(
    parameter int ram_words = 256
) (
    input  logic        clock,
    input  logic        reset,

    input  logic        uop_valid,
    output logic        uop_ready,
    input  uop_t        uop,

    output logic        redirect_valid,
    output logic [31:0] redirect_pc,

    output logic        wb_valid,
    input  logic        wb_ready,
    output wb_t         wb
);

    // ---------------------------------------------------------------------------
    // stage wiring
    // ---------------------------------------------------------------------------

    logic        exe_valid;
    logic        exe_ready;
    exe_result_t exe;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;

    exec_unit u_exec_unit (
        .clock          (clock),
        .reset          (reset),
        .uop_valid      (uop_valid),
        .uop_ready      (uop_ready),
        .uop            (uop),
        .exe_valid      (exe_valid),
        .exe_ready      (exe_ready),
        .exe            (exe),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    mem_access u_mem_access (
        .clock     (clock),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe       (exe),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb        (wb)
    );

    // data memory on the wishbone side
    data_ram #(
        .ram_words (ram_words)
    ) u_data_ram (
        .clock   (clock),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram import exec_pkg::*; #(
    parameter int ram_words = 256
) (
    input  logic    clock,
    input  logic    reset,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp
);

    localparam int addr_bits = $clog2(ram_words);

    logic [31:0]          mem [ram_words];
    logic [addr_bits-1:0] idx;
    logic                 req;

    // word index, wraps with the ram size
    assign idx = bus_req.adr[addr_bits+1:2];
    assign req = bus_req.cyc & bus_req.stb & ~bus_rsp.ack;

    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = 32'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bus_rsp.ack <= 1'b0;
        end else begin
            bus_rsp.ack <= req;
        end
    end

    // byte lane writes, read data lands with ack
    always_ff @(posedge clock) begin
        if (req) begin
            bus_rsp.dat_r <= mem[idx];
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_req.we && bus_req.sel[lane]) begin
                    mem[idx][lane*8 +: 8] <= bus_req.dat_w[lane*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access import exec_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  logic        exe_valid,
    output logic        exe_ready,
    input  exe_result_t exe,

    output wb_req_t     bus_req,
    input  wb_rsp_t     bus_rsp,

    output logic        wb_valid,
    input  logic        wb_ready,
    output wb_t         wb
);

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_hold
    } state_e;

    state_e      state;
    logic        accept;
    logic        in_bus;
    logic [3:0]  st_sel;
    logic [31:0] st_data;
    logic        req_we;
    logic [3:0]  req_sel;
    logic [31:0] req_adr;
    logic [31:0] req_dat;
    mem_size_e   ld_size;
    logic        ld_unsigned;

    // pick the addressed lane out of the read word and extend it
    function automatic logic [31:0] load_extend(input logic [31:0] word,
                                                input logic [1:0]  offset,
                                                input mem_size_e   size,
                                                input logic        is_unsigned);
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        lane_b = word[{offset, 3'b000} +: 8];
        lane_h = offset[1] ? word[31:16] : word[15:0];
        case (size)
            size_byte: load_extend = {{24{lane_b[7] & ~is_unsigned}}, lane_b};
            size_half: load_extend = {{16{lane_h[15] & ~is_unsigned}}, lane_h};
            default:   load_extend = word;
        endcase
    endfunction

    assign exe_ready = state == st_idle;
    assign accept    = exe_valid & exe_ready;
    assign in_bus    = state == st_bus;
    assign wb_valid  = state == st_hold;

    // store lanes from size and low address bits
    always_comb begin
        case (exe.mem_size)
            size_byte: begin
                st_sel  = 4'b0001 << exe.value[1:0];
                st_data = {4{exe.store_data[7:0]}};
            end
            size_half: begin
                st_sel  = exe.value[1] ? 4'b1100 : 4'b0011;
                st_data = {2{exe.store_data[15:0]}};
            end
            default: begin
                st_sel  = 4'b1111;
                st_data = exe.store_data;
            end
        endcase
    end

    assign bus_req = '{cyc: in_bus, stb: in_bus, we: req_we, sel: req_sel,
                       adr: req_adr, dat_w: req_dat};

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (exe_valid) state <= (exe.mem_kind == mem_none) ? st_hold : st_bus;
                st_bus:  if (bus_rsp.ack) state <= st_hold;
                st_hold: if (wb_ready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_we       <= exe.mem_kind == mem_store;
            req_sel      <= st_sel;
            req_adr      <= exe.value;
            req_dat      <= st_data;
            ld_size      <= exe.mem_size;
            ld_unsigned  <= exe.mem_unsigned;
            wb.rd        <= exe.rd;
            wb.reg_write <= exe.reg_write & (exe.mem_kind != mem_store);
            wb.data      <= exe.value;
        end
        // stores leave zero as their data
        if (in_bus && bus_rsp.ack) begin
            wb.data <= req_we ? 32'b0 :
                       load_extend(bus_rsp.dat_r, req_adr[1:0], ld_size, ld_unsigned);
        end
    end

endmodule

`default_nettype wire

/* exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import exec_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    input  logic        uop_valid,
    output logic        uop_ready,
    input  uop_t        uop,

    output logic        exe_valid,
    input  logic        exe_ready,
    output exe_result_t exe,

    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic        accept;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    alu_op_e     alu_op;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;
    logic        br_taken;
    logic [31:0] target;

    // ---------------------------------------------------------------------------
    // handshake
    // ---------------------------------------------------------------------------

    // one result slot, refilled in the cycle it drains
    assign uop_ready = ~exe_valid | exe_ready;
    assign accept    = uop_valid & uop_ready;

    // ---------------------------------------------------------------------------
    // operands and alu
    // ---------------------------------------------------------------------------

    always_comb begin
        alu_op = uop.alu_op;
        case (uop.src_sel)
            src_rs1_rs2:  begin alu_a = uop.rs1; alu_b = uop.rs2; end
            src_rs1_imm:  begin alu_a = uop.rs1; alu_b = uop.imm; end
            src_pc_imm:   begin alu_a = uop.pc;  alu_b = uop.imm; end
            default:      begin alu_a = uop.imm; alu_b = 32'b0;   end
        endcase
        // address generation for loads and stores
        if (uop.mem_kind != mem_none) begin
            alu_a  = uop.rs1;
            alu_b  = uop.imm;
            alu_op = alu_add;
        end
    end

    exec_alu u_alu (
        .a   (alu_a),
        .b   (alu_b),
        .op  (alu_op),
        .res (alu_res)
    );

    // ---------------------------------------------------------------------------
    // branch decision and target
    // ---------------------------------------------------------------------------

    assign pc_plus4 = uop.pc + 32'd4;

    always_comb begin
        case (uop.br_cond)
            br_eq:   br_taken = uop.rs1 == uop.rs2;
            br_ne:   br_taken = uop.rs1 != uop.rs2;
            br_lt:   br_taken = $signed(uop.rs1) < $signed(uop.rs2);
            br_ge:   br_taken = $signed(uop.rs1) >= $signed(uop.rs2);
            br_ltu:  br_taken = uop.rs1 < uop.rs2;
            br_geu:  br_taken = uop.rs1 >= uop.rs2;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (uop.flow)
            flow_branch: target = br_taken ? uop.pc + uop.imm : pc_plus4;
            flow_jalr:   target = (uop.rs1 + uop.imm) & ~32'd1;
            default:     target = uop.pc + uop.imm;
        endcase
    end

    // ---------------------------------------------------------------------------
    // result and redirect registers
    // ---------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            exe_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= accept & (uop.flow != flow_none);
            if (accept) begin
                exe_valid <= 1'b1;
            end else if (exe_ready) begin
                exe_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            exe.rd           <= uop.rd;
            // branches never write a register
            exe.reg_write    <= uop.reg_write & (uop.flow != flow_branch);
            exe.value        <= (uop.flow == flow_jal || uop.flow == flow_jalr) ?
                                pc_plus4 : alu_res;
            exe.mem_kind     <= uop.mem_kind;
            exe.mem_size     <= uop.mem_size;
            exe.mem_unsigned <= uop.mem_unsigned;
            exe.store_data   <= uop.rs2;
            redirect_pc      <= target;
        end
    end

endmodule

`default_nettype wire

/* exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     op,
    output logic [31:0] res
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits count for rv32 shifts
    assign shamt = b[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add: begin
                res = a + b;
            end
            alu_sub: begin
                res = a - b;
            end
            alu_sll: begin
                res = a << shamt;
            end
            alu_slt: begin
                res = {31'b0, lt_signed};
            end
            alu_sltu: begin
                res = {31'b0, lt_unsigned};
            end
            alu_xor: begin
                res = a ^ b;
            end
            alu_srl: begin
                res = a >> shamt;
            end
            alu_sra: begin
                res = $signed(a) >>> shamt;
            end
            alu_or: begin
                res = a | b;
            end
            alu_and: begin
                res = a & b;
            end
            default: begin
                res = a + b;
            end
        endcase
    end

endmodule

`default_nettype wire

/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // ---------------------------------------------------------------------------
    // operation encodings
    // ---------------------------------------------------------------------------

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // operand pairs fed to the alu
    typedef enum logic [1:0] {
        src_rs1_rs2,
        src_rs1_imm,
        src_pc_imm,
        src_imm_zero
    } src_sel_e;

    typedef enum logic [1:0] {
        flow_none,
        flow_branch,
        flow_jal,
        flow_jalr
    } flow_e;

    typedef enum logic [2:0] {
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_cond_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_kind_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    // ---------------------------------------------------------------------------
    // stage payloads
    // ---------------------------------------------------------------------------

    // decoded micro-op with operands already read
    typedef struct packed {
        alu_op_e     alu_op;
        src_sel_e    src_sel;
        flow_e       flow;
        br_cond_e    br_cond;
        mem_kind_e   mem_kind;
        mem_size_e   mem_size;
        logic        mem_unsigned;
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } uop_t;

    // value is alu result, link address or memory address
    typedef struct packed {
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] value;
        mem_kind_e   mem_kind;
        mem_size_e   mem_size;
        logic        mem_unsigned;
        logic [31:0] store_data;
    } exe_result_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] data;
    } wb_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat_w;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire
